/* verilog/sdram_cmd_pkg.sv */
package sdram_cmd_pkg;

  // Command pins in the order nCS, nRAS, nCAS, nWE
  typedef enum logic [3:0] {
    NOP          = 4'b0111,
    ACTIVE       = 4'b0011,
    READ         = 4'b0101,
    WRITE        = 4'b0100,
    PRECHARGE    = 4'b0010,
    AUTO_REFRESH = 4'b0001,
    LOAD_MODE    = 4'b0000
  } sdram_cmd_t;

  // Port and DQ widths
  localparam int ADDR_W   = 25;
  localparam int DATA_W   = 16;
  localparam int BYTES    = 2;
  localparam int RESULT_W = 32;

  // Word address split into bank, row and column
  localparam int ROW_W    = 13;
  localparam int ROW_LSB  = 10;
  localparam int BANK_W   = 2;
  localparam int BANK_LSB = 23;
  localparam int COL_W    = 10;
  // A10 selects auto precharge, or all banks on PRECHARGE
  localparam int AP_BIT    = 10;
  localparam int BURST_LEN = 2;

  // Reserved, single-word write, standard op, CL 2, sequential, burst of two
  localparam logic [ROW_W-1:0] MODE_WORD = {3'b000, 1'b1, 2'b00, 3'b010, 1'b0, 3'b001};

endpackage

/* verilog/sdram_timing_pkg.sv */
package sdram_timing_pkg;

  // Counter width shared by delay, init and refresh counts
  localparam int TIMER_W = 12;
  typedef logic [TIMER_W-1:0] timer_t;

  // Init timeline, in cycles from the end of reset
  localparam int T_CKE_ON       = 500;
  localparam int T_PRECHARGE_AT = 1100;

  // Command spacing at the 100 ns clock
  localparam int T_RP             = 1;
  localparam int T_RFC            = 1;
  localparam int T_MRD            = 2;
  localparam int T_RCD            = 1;
  localparam int T_WRITE_RECOVERY = 1;
  localparam int CAS_LAT          = 2;
  localparam int INPUT_REG_DELAY  = 1;
  localparam int REFRESH_INTERVAL = 75;

  // Later init points follow from precharge-all
  localparam int T_REFRESH1_AT = T_PRECHARGE_AT + T_RP;
  localparam int T_REFRESH2_AT = T_REFRESH1_AT + T_RFC;
  localparam int T_MODE_AT     = T_REFRESH2_AT + T_RFC;
  localparam int T_INIT_DONE   = T_MODE_AT + T_MRD;

endpackage

/* verilog/sdram_req_queue.sv */
`timescale 1ns/1ps

module sdram_req_queue (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [sdram_cmd_pkg::ADDR_W-1:0] addr,
  input  logic [sdram_cmd_pkg::DATA_W-1:0] wdata,
  input  logic [sdram_cmd_pkg::BYTES-1:0]  byte_en,
  input  logic                             wr_req,
  input  logic                             rd_req,
  input  logic                             take,
  output logic                             pending,
  output logic                             pend_write,
  output logic [sdram_cmd_pkg::ADDR_W-1:0] pend_addr,
  output logic [sdram_cmd_pkg::DATA_W-1:0] pend_wdata,
  output logic [sdram_cmd_pkg::BYTES-1:0]  pend_byte_en
);

  // Entry is free when empty or being taken this cycle
  logic accept;

  assign accept = (wr_req || rd_req) && (!pending || take);

  always_ff @(posedge clk) begin
    if (reset) begin
      pending    <= 1'b0;
      pend_write <= 1'b0;
    end else if (accept) begin
      pending <= 1'b1;
      // Write wins when both strobes arrive together
      pend_write <= wr_req;
    end else if (take) begin
      pending <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      pend_addr    <= addr;
      pend_wdata   <= wdata;
      pend_byte_en <= byte_en;
    end
  end

endmodule

/* verilog/sdram_timer.sv */
`timescale 1ns/1ps

module sdram_timer (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     delay_load,
  input  sdram_timing_pkg::timer_t delay_value,
  input  logic                     refresh_clear,
  input  logic                     init_complete,
  output logic                     delay_done,
  output logic                     refresh_due,
  output sdram_timing_pkg::timer_t init_count
);

  sdram_timing_pkg::timer_t count;
  sdram_timing_pkg::timer_t refresh_cnt;

  // Up count during init, loadable down count afterwards
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (!init_complete) begin
      count <= count + 1'b1;
    end else if (delay_load) begin
      count <= delay_value;
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  assign delay_done = (count == '0);
  assign init_count = count;

  // Refresh interval, holds once due until the FSM issues the refresh
  always_ff @(posedge clk) begin
    if (reset || refresh_clear) begin
      refresh_cnt <= '0;
    end else if (init_complete && !refresh_due) begin
      refresh_cnt <= refresh_cnt + 1'b1;
    end
  end

  assign refresh_due =
    (refresh_cnt >= sdram_timing_pkg::timer_t'(sdram_timing_pkg::REFRESH_INTERVAL));

endmodule

/* verilog/sdram_ctrl_fsm.sv */
`timescale 1ns/1ps

module sdram_ctrl_fsm (
  input  logic                                      clk,
  input  logic                                      reset,
  // Queue side
  input  logic                                      pending,
  input  logic                                      pend_write,
  input  logic [sdram_cmd_pkg::ADDR_W-1:0]          pend_addr,
  input  logic [sdram_cmd_pkg::DATA_W-1:0]          pend_wdata,
  input  logic [sdram_cmd_pkg::BYTES-1:0]           pend_byte_en,
  output logic                                      take,
  // Timer side
  input  logic                                      delay_done,
  input  logic                                      refresh_due,
  input  sdram_timing_pkg::timer_t                  init_count,
  output logic                                      delay_load,
  output sdram_timing_pkg::timer_t                  delay_value,
  output logic                                      refresh_clear,
  // Command bus side
  output sdram_cmd_pkg::sdram_cmd_t                 cmd,
  output logic                                      ba_load,
  output logic [sdram_cmd_pkg::BANK_W-1:0]          ba,
  output logic [sdram_cmd_pkg::ROW_W-1:0]           a_value,
  output logic [sdram_cmd_pkg::BYTES-1:0]           dqm_value,
  output logic [sdram_cmd_pkg::DATA_W-1:0]          dq_value,
  output logic                                      dq_drive,
  // Read collector side
  output logic                                      capture_en,
  output logic                                      word_index,
  // Chip and port status
  output logic                                      cke,
  output logic                                      init_complete,
  output logic                                      available,
  output logic                                      ready
);

  typedef enum logic [2:0] {INIT, IDLE, WAIT, WRITE, READ, CAPTURE} state_t;

  state_t state;
  state_t ret_state;
  // Set when the current WAIT ends a write and must pulse ready
  logic   notify;
  logic   word_cnt;

  // Request fields kept once the queue entry is taken
  logic [sdram_cmd_pkg::COL_W-1:0]  cur_col;
  logic [sdram_cmd_pkg::DATA_W-1:0] cur_wdata;
  logic [sdram_cmd_pkg::BYTES-1:0]  cur_be;

  assign init_complete = (state != INIT);
  assign available     = (state == IDLE) && !pending;
  assign word_index    = word_cnt;

  //////////////////////////////
  // State register
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= INIT;
      ret_state <= IDLE;
      notify    <= 1'b0;
      word_cnt  <= 1'b0;
      cke       <= 1'b0;
      ready     <= 1'b0;
    end else begin
      ready <= 1'b0;
      case (state)
        INIT: begin
          // CKE rises well ahead of precharge-all
          if (init_count == sdram_timing_pkg::timer_t'(sdram_timing_pkg::T_CKE_ON)) begin
            cke <= 1'b1;
          end
          if (init_count == sdram_timing_pkg::timer_t'(sdram_timing_pkg::T_INIT_DONE)) begin
            state <= IDLE;
          end
        end
        IDLE: begin
          // Refresh first, then the queued request
          if (refresh_due) begin
            state     <= WAIT;
            ret_state <= IDLE;
            notify    <= 1'b0;
          end else if (pending) begin
            state     <= WAIT;
            ret_state <= pend_write ? WRITE : READ;
            notify    <= 1'b0;
          end
        end
        WAIT: begin
          if (delay_done) begin
            state <= ret_state;
            ready <= notify;
          end
        end
        WRITE: begin
          // Write recovery, then ready on the way back to idle
          state     <= WAIT;
          ret_state <= IDLE;
          notify    <= 1'b1;
        end
        READ: begin
          state     <= WAIT;
          ret_state <= CAPTURE;
          word_cnt  <= 1'b0;
        end
        CAPTURE: begin
          if (word_cnt == 1'(sdram_cmd_pkg::BURST_LEN - 1)) begin
            state <= IDLE;
            ready <= 1'b1;
          end else begin
            word_cnt <= word_cnt + 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Latch column, data and enables as the entry leaves the queue
  always_ff @(posedge clk) begin
    if (take) begin
      cur_col   <= pend_addr[sdram_cmd_pkg::COL_W-1:0];
      cur_wdata <= pend_wdata;
      cur_be    <= pend_byte_en;
    end
  end

  //////////////////////////////
  // Command decode
  //////////////////////////////

  always_comb begin
    cmd           = sdram_cmd_pkg::NOP;
    ba_load       = 1'b0;
    ba            = pend_addr[sdram_cmd_pkg::BANK_LSB +: sdram_cmd_pkg::BANK_W];
    a_value       = '0;
    dqm_value     = '0;
    dq_value      = cur_wdata;
    dq_drive      = 1'b0;
    delay_load    = 1'b0;
    delay_value   = '0;
    refresh_clear = 1'b0;
    capture_en    = 1'b0;
    take          = 1'b0;
    case (state)
      INIT: begin
        if (init_count == sdram_timing_pkg::timer_t'(sdram_timing_pkg::T_PRECHARGE_AT)) begin
          cmd                           = sdram_cmd_pkg::PRECHARGE;
          a_value[sdram_cmd_pkg::AP_BIT] = 1'b1;
        end else if (init_count == sdram_timing_pkg::timer_t'(sdram_timing_pkg::T_REFRESH1_AT) ||
                     init_count == sdram_timing_pkg::timer_t'(sdram_timing_pkg::T_REFRESH2_AT)) begin
          cmd = sdram_cmd_pkg::AUTO_REFRESH;
        end else if (init_count == sdram_timing_pkg::timer_t'(sdram_timing_pkg::T_MODE_AT)) begin
          // Mode register sits in bank 0
          cmd     = sdram_cmd_pkg::LOAD_MODE;
          ba      = '0;
          ba_load = 1'b1;
          a_value = sdram_cmd_pkg::MODE_WORD;
        end
      end
      IDLE: begin
        if (refresh_due) begin
          cmd           = sdram_cmd_pkg::AUTO_REFRESH;
          refresh_clear = 1'b1;
          delay_load    = 1'b1;
          delay_value   = sdram_timing_pkg::timer_t'(sdram_timing_pkg::T_RFC - 1);
        end else if (pending) begin
          // Open the row, bank is held for the column command
          cmd         = sdram_cmd_pkg::ACTIVE;
          ba_load     = 1'b1;
          a_value     = pend_addr[sdram_cmd_pkg::ROW_LSB +: sdram_cmd_pkg::ROW_W];
          take        = 1'b1;
          delay_load  = 1'b1;
          delay_value = sdram_timing_pkg::timer_t'(sdram_timing_pkg::T_RCD - 1);
        end
      end
      WRITE: begin
        cmd                                 = sdram_cmd_pkg::WRITE;
        a_value[sdram_cmd_pkg::COL_W-1:0]   = cur_col;
        a_value[sdram_cmd_pkg::AP_BIT]      = 1'b1;
        dqm_value                           = ~cur_be;
        dq_drive                            = 1'b1;
        delay_load                          = 1'b1;
        delay_value = sdram_timing_pkg::timer_t'(sdram_timing_pkg::T_WRITE_RECOVERY - 1);
      end
      READ: begin
        cmd                               = sdram_cmd_pkg::READ;
        a_value[sdram_cmd_pkg::COL_W-1:0] = cur_col;
        a_value[sdram_cmd_pkg::AP_BIT]    = 1'b1;
        delay_load                        = 1'b1;
        // Two of the latency cycles are the READ and first CAPTURE states
        delay_value = sdram_timing_pkg::timer_t'(sdram_timing_pkg::CAS_LAT +
                                                 sdram_timing_pkg::INPUT_REG_DELAY - 2);
      end
      CAPTURE: capture_en = 1'b1;
      default: ;
    endcase
  end

endmodule

/* verilog/sdram_cmd_bus.sv */
`timescale 1ns/1ps

module sdram_cmd_bus (
  input  logic                             clk,
  input  logic                             reset,
  input  sdram_cmd_pkg::sdram_cmd_t        cmd,
  input  logic                             ba_load,
  input  logic [sdram_cmd_pkg::BANK_W-1:0] ba_value,
  input  logic [sdram_cmd_pkg::ROW_W-1:0]  a_value,
  input  logic [sdram_cmd_pkg::BYTES-1:0]  dqm_value,
  input  logic [sdram_cmd_pkg::DATA_W-1:0] dq_value,
  input  logic                             dq_drive,
  output logic [3:0]                       cmd_n,
  output logic [sdram_cmd_pkg::BANK_W-1:0] ba,
  output logic [sdram_cmd_pkg::ROW_W-1:0]  a,
  output logic [sdram_cmd_pkg::BYTES-1:0]  dqm,
  inout  wire  [sdram_cmd_pkg::DATA_W-1:0] dq
);

  logic [sdram_cmd_pkg::DATA_W-1:0] dq_out;
  logic                             dq_oe;

  // Command and output enable, NOP and released bus out of reset
  always_ff @(posedge clk) begin
    if (reset) begin
      cmd_n <= sdram_cmd_pkg::NOP;
      dq_oe <= 1'b0;
    end else begin
      cmd_n <= cmd;
      dq_oe <= dq_drive;
    end
  end

  // Address and data follow the command on the same edge
  always_ff @(posedge clk) begin
    a      <= a_value;
    dqm    <= dqm_value;
    dq_out <= dq_value;
    // Bank stays put from ACTIVE through READ or WRITE
    if (ba_load) begin
      ba <= ba_value;
    end
  end

  assign dq = dq_oe ? dq_out : 'z;

endmodule

/* verilog/sdram_read_collect.sv */
`timescale 1ns/1ps

module sdram_read_collect (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               capture_en,
  input  logic                               word_index,
  input  logic [sdram_cmd_pkg::DATA_W-1:0]   dq,
  output logic [sdram_cmd_pkg::RESULT_W-1:0] q
);

  // DQ is sampled straight off the pins, this register is the input stage
  always_ff @(posedge clk) begin
    if (reset) begin
      q <= '0;
    end else if (capture_en) begin
      // Word 0 lands in the low half
      q[word_index * sdram_cmd_pkg::DATA_W +: sdram_cmd_pkg::DATA_W] <= dq;
    end
  end

endmodule

/* verilog/sdram_ctrl_top.sv */
`timescale 1ns/1ps

module sdram_ctrl_top (
  input  logic                               clk,
  input  logic                               reset,
  // User port
  input  logic [sdram_cmd_pkg::ADDR_W-1:0]   addr,
  input  logic [sdram_cmd_pkg::DATA_W-1:0]   wdata,
  input  logic [sdram_cmd_pkg::BYTES-1:0]    byte_en,
  input  logic                               wr_req,
  input  logic                               rd_req,
  output logic [sdram_cmd_pkg::RESULT_W-1:0] q,
  output logic                               available,
  output logic                               ready,
  output logic                               init_complete,
  // Chip pins
  output logic [3:0]                         cmd_n,
  output logic [sdram_cmd_pkg::BANK_W-1:0]   ba,
  output logic [sdram_cmd_pkg::ROW_W-1:0]    a,
  output logic [sdram_cmd_pkg::BYTES-1:0]    dqm,
  output logic                               cke,
  inout  wire  [sdram_cmd_pkg::DATA_W-1:0]   dq
);

  // Queue to FSM
  logic                             pending;
  logic                             pend_write;
  logic [sdram_cmd_pkg::ADDR_W-1:0] pend_addr;
  logic [sdram_cmd_pkg::DATA_W-1:0] pend_wdata;
  logic [sdram_cmd_pkg::BYTES-1:0]  pend_byte_en;
  logic                             take;

  // Timer handshake
  logic                     delay_load;
  logic                     delay_done;
  logic                     refresh_due;
  logic                     refresh_clear;
  sdram_timing_pkg::timer_t delay_value;
  sdram_timing_pkg::timer_t init_count;

  // FSM to command bus and collector
  sdram_cmd_pkg::sdram_cmd_t        cmd;
  logic                             ba_load;
  logic [sdram_cmd_pkg::BANK_W-1:0] ba_value;
  logic [sdram_cmd_pkg::ROW_W-1:0]  a_value;
  logic [sdram_cmd_pkg::BYTES-1:0]  dqm_value;
  logic [sdram_cmd_pkg::DATA_W-1:0] dq_value;
  logic                             dq_drive;
  logic                             capture_en;
  logic                             word_index;

  sdram_req_queue sdram_req_queue_i (
    .clk          (clk),
    .reset        (reset),
    .addr         (addr),
    .wdata        (wdata),
    .byte_en      (byte_en),
    .wr_req       (wr_req),
    .rd_req       (rd_req),
    .take         (take),
    .pending      (pending),
    .pend_write   (pend_write),
    .pend_addr    (pend_addr),
    .pend_wdata   (pend_wdata),
    .pend_byte_en (pend_byte_en)
  );

  sdram_timer sdram_timer_i (
    .clk           (clk),
    .reset         (reset),
    .delay_load    (delay_load),
    .delay_value   (delay_value),
    .refresh_clear (refresh_clear),
    .init_complete (init_complete),
    .delay_done    (delay_done),
    .refresh_due   (refresh_due),
    .init_count    (init_count)
  );

  sdram_ctrl_fsm sdram_ctrl_fsm_i (
    .clk           (clk),
    .reset         (reset),
    .pending       (pending),
    .pend_write    (pend_write),
    .pend_addr     (pend_addr),
    .pend_wdata    (pend_wdata),
    .pend_byte_en  (pend_byte_en),
    .take          (take),
    .delay_done    (delay_done),
    .refresh_due   (refresh_due),
    .init_count    (init_count),
    .delay_load    (delay_load),
    .delay_value   (delay_value),
    .refresh_clear (refresh_clear),
    .cmd           (cmd),
    .ba_load       (ba_load),
    .ba            (ba_value),
    .a_value       (a_value),
    .dqm_value     (dqm_value),
    .dq_value      (dq_value),
    .dq_drive      (dq_drive),
    .capture_en    (capture_en),
    .word_index    (word_index),
    .cke           (cke),
    .init_complete (init_complete),
    .available     (available),
    .ready         (ready)
  );

  sdram_cmd_bus sdram_cmd_bus_i (
    .clk       (clk),
    .reset     (reset),
    .cmd       (cmd),
    .ba_load   (ba_load),
    .ba_value  (ba_value),
    .a_value   (a_value),
    .dqm_value (dqm_value),
    .dq_value  (dq_value),
    .dq_drive  (dq_drive),
    .cmd_n     (cmd_n),
    .ba        (ba),
    .a         (a),
    .dqm       (dqm),
    .dq        (dq)
  );

  sdram_read_collect sdram_read_collect_i (
    .clk        (clk),
    .reset      (reset),
    .capture_en (capture_en),
    .word_index (word_index),
    .dq         (dq),
    .q          (q)
  );

endmodule

/* dv/sdram_model.sv */
`timescale 1ns/1ps

module sdram_model (
  input  logic                             clk,
  input  logic                             cke,
  input  logic [3:0]                       cmd_n,
  input  logic [sdram_cmd_pkg::BANK_W-1:0] ba,
  input  logic [sdram_cmd_pkg::ROW_W-1:0]  a,
  input  logic [sdram_cmd_pkg::BYTES-1:0]  dqm,
  inout  wire  [sdram_cmd_pkg::DATA_W-1:0] dq
);

  // Sparse storage keyed by bank, row and column
  logic [sdram_cmd_pkg::DATA_W-1:0] mem [int unsigned];
  logic [sdram_cmd_pkg::ROW_W-1:0]  open_row [0:3];

  // Command log read back by the testbench
  int                               cycle_no   = 0;
  int                               refresh_times[$];
  int                               mode_loads = 0;
  logic [sdram_cmd_pkg::ROW_W-1:0]  mode_word  = '0;
  logic [sdram_cmd_pkg::BANK_W-1:0] mode_ba    = '0;

  // Read burst in flight
  logic [sdram_cmd_pkg::ADDR_W-1:0] rd_addr   = '0;
  int                               rd_start  = 0;
  logic                             rd_active = 1'b0;
  logic [sdram_cmd_pkg::DATA_W-1:0] dq_out    = '0;
  logic                             dq_oe     = 1'b0;

  assign dq = dq_oe ? dq_out : 'z;

  // Unwritten words read as zero
  function automatic logic [sdram_cmd_pkg::DATA_W-1:0] fetch(
    input logic [sdram_cmd_pkg::ADDR_W-1:0] key
  );
    if (mem.exists(key)) begin
      return mem[key];
    end
    return '0;
  endfunction

  // Only bytes with DQM low are written
  task automatic store_word(input logic [sdram_cmd_pkg::ADDR_W-1:0] key);
    logic [sdram_cmd_pkg::DATA_W-1:0] word;
    word = fetch(key);
    for (int b = 0; b < sdram_cmd_pkg::BYTES; b++) begin
      if (!dqm[b]) begin
        word[b*8 +: 8] = dq[b*8 +: 8];
      end
    end
    mem[key] = word;
  endtask

  always @(posedge clk) begin
    cycle_no++;
    if (cke) begin
      case (cmd_n)
        sdram_cmd_pkg::ACTIVE: open_row[ba] = a;
        sdram_cmd_pkg::WRITE: store_word({ba, open_row[ba], a[sdram_cmd_pkg::COL_W-1:0]});
        sdram_cmd_pkg::READ: begin
          rd_addr   = {ba, open_row[ba], a[sdram_cmd_pkg::COL_W-1:0]};
          rd_start  = cycle_no;
          rd_active = 1'b1;
        end
        sdram_cmd_pkg::AUTO_REFRESH: refresh_times.push_back(cycle_no);
        sdram_cmd_pkg::LOAD_MODE: begin
          mode_word = a;
          mode_ba   = ba;
          mode_loads++;
        end
        default: ;
      endcase
    end
    // Sequential burst of two, second word is the other one of the aligned pair
    if (rd_active) begin
      if (cycle_no == rd_start + sdram_timing_pkg::CAS_LAT - 1) begin
        dq_out <= fetch(rd_addr);
        dq_oe  <= 1'b1;
      end else if (cycle_no == rd_start + sdram_timing_pkg::CAS_LAT) begin
        dq_out <= fetch(rd_addr ^ 1);
      end else if (cycle_no == rd_start + sdram_timing_pkg::CAS_LAT + 1) begin
        dq_oe     <= 1'b0;
        rd_active = 1'b0;
      end
    end
  end

endmodule

/* dv/sdram_ctrl_asserts.sv */
`timescale 1ns/1ps

module sdram_ctrl_asserts (
  input logic       clk,
  input logic       reset,
  input logic       ready,
  input logic       dq_drive,
  input logic [3:0] cmd_n,
  input logic       init_complete
);

  // Ready is a single-cycle pulse
  ready_single: assert property (@(posedge clk) disable iff (reset) ready |=> !ready)
    else $error("ready high for two cycles in a row");

  // Data drive request lands together with WRITE on the pins
  drive_with_write: assert property (@(posedge clk) disable iff (reset)
    dq_drive |=> (cmd_n == sdram_cmd_pkg::WRITE))
    else $error("dq driven without a WRITE command");

  write_has_drive: assert property (@(posedge clk) disable iff (reset)
    (cmd_n == sdram_cmd_pkg::WRITE) |-> $past(dq_drive))
    else $error("WRITE command without dq drive");

  // Once up, the controller stays initialized
  init_stays: assert property (@(posedge clk) disable iff (reset)
    init_complete |=> init_complete)
    else $error("init_complete fell outside reset");

endmodule

bind sdram_ctrl_top sdram_ctrl_asserts sdram_ctrl_asserts_i (
  .clk           (clk),
  .reset         (reset),
  .ready         (ready),
  .dq_drive      (dq_drive),
  .cmd_n         (cmd_n),
  .init_complete (init_complete)
);

/* dv/sdram_tb.sv */
`timescale 1ns/1ps

module sdram_tb;

  // Init window, eight port operations, the refresh window, then margin
  localparam int TIMEOUT_CYCLES = 1500 + 40 * 8 + 300 + 200;

  logic                               clk;
  logic                               reset;
  logic [sdram_cmd_pkg::ADDR_W-1:0]   addr;
  logic [sdram_cmd_pkg::DATA_W-1:0]   wdata;
  logic [sdram_cmd_pkg::BYTES-1:0]    byte_en;
  logic                               wr_req;
  logic                               rd_req;
  logic [sdram_cmd_pkg::RESULT_W-1:0] q;
  logic                               available;
  logic                               ready;
  logic                               init_complete;
  logic [3:0]                         cmd_n;
  logic [sdram_cmd_pkg::BANK_W-1:0]   ba;
  logic [sdram_cmd_pkg::ROW_W-1:0]    a;
  logic [sdram_cmd_pkg::BYTES-1:0]    dqm;
  logic                               cke;
  wire  [sdram_cmd_pkg::DATA_W-1:0]   dq;

  int cycle_count = 0;
  int check_count = 0;
  int error_count = 0;
  // Ready pulses seen at the sampling points
  int ready_seen  = 0;

  sdram_ctrl_top sdram_ctrl_top_i (
    .clk           (clk),
    .reset         (reset),
    .addr          (addr),
    .wdata         (wdata),
    .byte_en       (byte_en),
    .wr_req        (wr_req),
    .rd_req        (rd_req),
    .q             (q),
    .available     (available),
    .ready         (ready),
    .init_complete (init_complete),
    .cmd_n         (cmd_n),
    .ba            (ba),
    .a             (a),
    .dqm           (dqm),
    .cke           (cke),
    .dq            (dq)
  );

  sdram_model model_i (
    .clk   (clk),
    .cke   (cke),
    .cmd_n (cmd_n),
    .ba    (ba),
    .a     (a),
    .dqm   (dqm),
    .dq    (dq)
  );

  always #50 clk = ~clk;

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Advance to 5 ns past the next rising edge
  task automatic next_cycle();
    @(posedge clk);
    #5;
    if (ready) begin
      ready_seen++;
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    check_count++;
    assert (cond) else begin
      $display("Check failed: %s", what);
      error_count++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (error_count == errs_before) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d errors", name, error_count - errs_before);
    end
  endtask

  task automatic wait_available();
    while (!available) begin
      next_cycle();
    end
  endtask

  // One-cycle write strobe, then wait for its ready pulse
  task automatic write_word(input logic [sdram_cmd_pkg::ADDR_W-1:0] waddr,
                            input logic [sdram_cmd_pkg::DATA_W-1:0] data,
                            input logic [sdram_cmd_pkg::BYTES-1:0]  be);
    wait_available();
    addr    = waddr;
    wdata   = data;
    byte_en = be;
    wr_req  = 1'b1;
    next_cycle();
    wr_req = 1'b0;
    while (!ready) begin
      next_cycle();
    end
  endtask

  // q is taken in the ready cycle
  task automatic read_burst(input  logic [sdram_cmd_pkg::ADDR_W-1:0]   raddr,
                            output logic [sdram_cmd_pkg::RESULT_W-1:0] result);
    wait_available();
    addr   = raddr;
    rd_req = 1'b1;
    next_cycle();
    rd_req = 1'b0;
    while (!ready) begin
      next_cycle();
    end
    result = q;
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic test_init();
    int          errs_before;
    logic [12:0] exp_mode;
    errs_before = error_count;
    // Mode fields by bit position
    exp_mode       = '0;
    // Single-word write
    exp_mode[9]    = 1'b1;
    // CAS latency 2
    exp_mode[6:4]  = 3'd2;
    // Sequential order
    exp_mode[3]    = 1'b0;
    // Burst length code 1
    exp_mode[2:0]  = 3'd1;
    while (!init_complete) begin
      next_cycle();
    end
    check_value("cke", cke, 1);
    check_value("mode loads", model_i.mode_loads, 1);
    check_value("mode word", model_i.mode_word, exp_mode);
    check_value("mode bank", model_i.mode_ba, 0);
    report_test("init", errs_before);
  endtask

  task automatic test_write_read();
    int                                 errs_before;
    logic [31:0]                        rnd;
    logic [sdram_cmd_pkg::ADDR_W-1:0]   base;
    logic [sdram_cmd_pkg::RESULT_W-1:0] result;
    errs_before = error_count;
    rnd  = $urandom();
    // Even start so both words sit in one burst pair
    base = rnd[sdram_cmd_pkg::ADDR_W-1:0] & ~25'd1;
    rnd  = $urandom();
    write_word(base, rnd[15:0], 2'b11);
    write_word(base + 1'b1, rnd[31:16], 2'b11);
    read_burst(base, result);
    check_value("q", result, {rnd[31:16], rnd[15:0]});
    report_test("write and read", errs_before);
  endtask

  task automatic test_byte_enable();
    int                                 errs_before;
    logic [31:0]                        rnd;
    logic [sdram_cmd_pkg::ADDR_W-1:0]   waddr;
    logic [sdram_cmd_pkg::RESULT_W-1:0] result;
    errs_before = error_count;
    rnd   = $urandom();
    waddr = rnd[sdram_cmd_pkg::ADDR_W-1:0];
    rnd   = $urandom();
    write_word(waddr, rnd[15:0], 2'b11);
    // Low byte only so the high byte keeps the old value
    write_word(waddr, rnd[31:16], 2'b01);
    read_burst(waddr, result);
    check_value("q[15:0]", result[15:0], {rnd[15:8], rnd[23:16]});
    report_test("byte enables", errs_before);
  endtask

  task automatic test_queued_request();
    int          errs_before;
    int          pulses_before;
    logic [31:0] rnd;
    errs_before = error_count;
    rnd = $urandom();
    wait_available();
    pulses_before = ready_seen;
    addr    = rnd[sdram_cmd_pkg::ADDR_W-1:0];
    rnd     = $urandom();
    wdata   = rnd[15:0];
    byte_en = 2'b11;
    wr_req  = 1'b1;
    next_cycle();
    wr_req = 1'b0;
    // ACTIVE on the pins means the write left the queue
    while (cmd_n != sdram_cmd_pkg::ACTIVE) begin
      next_cycle();
    end
    check_value("available", available, 0);
    rd_req = 1'b1;
    next_cycle();
    rd_req = 1'b0;
    while (ready_seen - pulses_before < 2) begin
      next_cycle();
    end
    check_value("q[15:0]", q[15:0], rnd[15:0]);
    repeat (5) next_cycle();
    check_value("ready pulses", ready_seen - pulses_before, 2);
    report_test("queued request", errs_before);
  endtask

  task automatic test_refresh();
    int errs_before;
    int start;
    int stop;
    int prev;
    int t;
    int hits;
    int i;
    errs_before = error_count;
    start = model_i.cycle_no;
    repeat (300) next_cycle();
    stop = model_i.cycle_no;
    prev = start;
    hits = 0;
    for (i = 0; i < model_i.refresh_times.size(); i++) begin
      t = model_i.refresh_times[i];
      if (t > start) begin
        hits++;
        check_true(t - prev <= sdram_timing_pkg::REFRESH_INTERVAL + 10,
                   $sformatf("refresh gap of %0d cycles is too long", t - prev));
        prev = t;
      end
    end
    // Quiet tail after the last refresh must also stay within the limit
    check_true(stop - prev <= sdram_timing_pkg::REFRESH_INTERVAL + 10,
               $sformatf("no refresh in the last %0d cycles", stop - prev));
    check_true(hits >= 300 / (sdram_timing_pkg::REFRESH_INTERVAL + 10),
               $sformatf("only %0d refreshes in 300 idle cycles", hits));
    report_test("refresh", errs_before);
  endtask

  //////////////////////////////
  // Run control
  //////////////////////////////

  initial begin : watchdog
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout after %0d cycles, a test never finished", cycle_count);
    $display("Done: errors found");
    $finish;
  end

  initial begin : main
    logic [31:0] seed;
    clk     = 1'b0;
    reset   = 1'b1;
    addr    = '0;
    wdata   = '0;
    byte_en = '0;
    wr_req  = 1'b0;
    rd_req  = 1'b0;
    seed    = $urandom(61);
    // Reset over three rising edges
    repeat (3) @(posedge clk);
    #5;
    reset = 1'b0;
    test_init();
    test_write_read();
    test_byte_enable();
    test_queued_request();
    test_refresh();
    $display("Checks: %0d run, %0d failed", check_count, error_count);
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* tb.f */
verilog/sdram_cmd_pkg.sv
verilog/sdram_timing_pkg.sv
verilog/sdram_req_queue.sv
verilog/sdram_timer.sv
verilog/sdram_ctrl_fsm.sv
verilog/sdram_cmd_bus.sv
verilog/sdram_read_collect.sv
verilog/sdram_ctrl_top.sv
dv/sdram_model.sv
dv/sdram_ctrl_asserts.sv
dv/sdram_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = sdram_tb
FILELIST  = tb.f
OBJ_DIR   = obj_dir
PASS_MSG  = Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
